//--- verilog/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// --------------------
// data memory
// --------------------

// 32-bit words in the ramio data RAM
// word index wraps modulo the depth
`define RAM_DEPTH_WORDS 256

// --------------------
// mapped i/o
// --------------------

`define LED_ADDRESS 32'hFFFF_FFFC  // top word of the address space

`endif

//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

  // --------------------
  // encodings
  // --------------------

  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_op_imm = 7'b0010011,
    op_store  = 7'b0100011,
    op_op     = 7'b0110011,
    op_lui    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // lui, operand b straight through
  } alu_op_e;

  typedef enum logic [2:0] {
    mem_none,
    mem_byte,
    mem_byte_u,
    mem_half,
    mem_half_u,
    mem_word
  } mem_type_e;

  // --------------------
  // stage records
  // --------------------

  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] imm;
    logic        use_imm;     // operand b from imm
    alu_op_e     alu_op;
    mem_type_e   mem_type;    // mem_none for alu ops
    logic        store;
    logic        illegal;
    logic        writes_reg;
  } decoded_t;

  typedef struct packed {
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;  // unaligned, ramio places it
    mem_type_e   mem_type;
    logic        write;
  } mem_req_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] result;
    mem_type_e   mem_type;
    logic [1:0]  addr_low;  // byte lane of a load
    logic        load;
    logic        illegal;
    logic        writes_reg;
  } executed_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
    logic        illegal;
  } retire_t;

endpackage

`default_nettype wire

//--- verilog/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
  input  wire                    clk,
  input  wire                    reset,
  input  wire [31:0]             instr,
  input  wire                    instr_valid,
  output logic [4:0]             rs1_index,
  output logic [4:0]             rs2_index,
  input  wire [31:0]             rs1_value,
  input  wire [31:0]             rs2_value,
  output logic                   dec_valid,
  output core_pkg::decoded_t     decoded
);

  import core_pkg::*;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_u;
  decoded_t    next;

  // funct3 to alu function, alt is funct7 bit 5
  function automatic alu_op_e alu_select(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  // --------------------
  // field split
  // --------------------
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u  = {instr[31:12], 12'b0};

  always_comb begin
    next          = '0;
    next.rd       = instr[11:7];
    next.alu_op   = alu_add;  // address calc default
    next.mem_type = mem_none;
    case (opcode)
      op_op: begin
        next.rs1        = instr[19:15];
        next.rs2        = instr[24:20];
        next.alu_op     = alu_select(funct3, funct7[5]);
        next.writes_reg = 1'b1;
        // only add/sub and srl/sra have an alternate form
        if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
          next.illegal = 1'b1;
      end
      op_op_imm: begin
        next.rs1        = instr[19:15];
        next.imm        = imm_i;
        next.use_imm    = 1'b1;
        next.alu_op     = alu_select(funct3, funct3 == 3'b101 && funct7[5]);  // no subi
        next.writes_reg = 1'b1;
        if (funct3 == 3'b001 && funct7 != 7'b0)
          next.illegal = 1'b1;  // bad slli
        if (funct3 == 3'b101 && funct7 != 7'b0 && funct7 != 7'b0100000)
          next.illegal = 1'b1;  // bad srli / srai
      end
      op_lui: begin
        next.imm        = imm_u;
        next.use_imm    = 1'b1;
        next.alu_op     = alu_pass_b;
        next.writes_reg = 1'b1;
      end
      op_load: begin
        next.rs1        = instr[19:15];
        next.imm        = imm_i;
        next.use_imm    = 1'b1;
        next.writes_reg = 1'b1;
        case (funct3)
          3'b000:  next.mem_type = mem_byte;
          3'b001:  next.mem_type = mem_half;
          3'b010:  next.mem_type = mem_word;
          3'b100:  next.mem_type = mem_byte_u;
          3'b101:  next.mem_type = mem_half_u;
          default: next.illegal  = 1'b1;
        endcase
      end
      op_store: begin
        next.rs1     = instr[19:15];
        next.rs2     = instr[24:20];  // store data
        next.imm     = imm_s;
        next.use_imm = 1'b1;
        next.store   = 1'b1;
        case (funct3)
          3'b000:  next.mem_type = mem_byte;
          3'b001:  next.mem_type = mem_half;
          3'b010:  next.mem_type = mem_word;
          default: next.illegal  = 1'b1;
        endcase
      end
      default: next.illegal = 1'b1;
    endcase
    if (next.illegal) begin  // no side effects at all
      next.writes_reg = 1'b0;
      next.store      = 1'b0;
      next.mem_type   = mem_none;
    end
    next.rs1_value = rs1_value;  // read back from register file
    next.rs2_value = rs2_value;
  end

  assign rs1_index = next.rs1;
  assign rs2_index = next.rs2;

  // --------------------
  // stage register
  // --------------------
  always_ff @(posedge clk) begin
    if (reset)
      dec_valid <= 1'b0;
    else
      dec_valid <= instr_valid;
  end

  always_ff @(posedge clk) begin
    decoded <= next;  // payload, qualified by dec_valid
  end

endmodule

`default_nettype wire

//--- verilog/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    dec_valid,
  input  core_pkg::decoded_t     decoded,
  input  wire                    wb_valid,
  input  wire [4:0]              wb_rd,
  input  wire [31:0]             wb_value,
  output logic                   mem_valid,
  output core_pkg::mem_req_t     mem_req,
  output logic                   exe_valid,
  output core_pkg::executed_t    executed
);

  import core_pkg::*;

  logic [31:0] op_a;
  logic [31:0] rs2_fwd;  // also the store data
  logic [31:0] op_b;
  logic [31:0] result;
  logic        is_load;
  executed_t   next;

  // --------------------
  // forwarding
  // --------------------
  // wb_valid is never set for x0, so no zero check here
  assign op_a    = (wb_valid && wb_rd == decoded.rs1) ? wb_value : decoded.rs1_value;
  assign rs2_fwd = (wb_valid && wb_rd == decoded.rs2) ? wb_value : decoded.rs2_value;
  assign op_b    = decoded.use_imm ? decoded.imm : rs2_fwd;

  // --------------------
  // alu
  // --------------------
  always_comb begin
    case (decoded.alu_op)
      alu_add:    result = op_a + op_b;  // also load/store address
      alu_sub:    result = op_a - op_b;
      alu_sll:    result = op_a << op_b[4:0];
      alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   result = {31'b0, op_a < op_b};
      alu_xor:    result = op_a ^ op_b;
      alu_srl:    result = op_a >> op_b[4:0];
      alu_sra:    result = $unsigned($signed(op_a) >>> op_b[4:0]);
      alu_or:     result = op_a | op_b;
      alu_and:    result = op_a & op_b;
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

  assign is_load = decoded.mem_type != mem_none && !decoded.store;

  // --------------------
  // memory request
  // --------------------
  assign mem_valid        = dec_valid && decoded.mem_type != mem_none;
  assign mem_req.addr     = result;
  assign mem_req.wdata    = rs2_fwd;
  assign mem_req.mem_type = decoded.mem_type;
  assign mem_req.write    = decoded.store;

  always_comb begin
    next            = '0;
    next.rd         = decoded.rd;
    next.result     = result;
    next.mem_type   = decoded.mem_type;
    next.addr_low   = result[1:0];  // lane select in result stage
    next.load       = is_load;
    next.illegal    = decoded.illegal;
    next.writes_reg = decoded.writes_reg;
  end

  // --------------------
  // stage register
  // --------------------
  always_ff @(posedge clk) begin
    if (reset)
      exe_valid <= 1'b0;
    else
      exe_valid <= dec_valid;
  end

  always_ff @(posedge clk) begin
    executed <= next;
  end

endmodule

`default_nettype wire

//--- verilog/result_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module result_writeback (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    exe_valid,
  input  core_pkg::executed_t    executed,
  input  wire [31:0]             rdata,
  input  wire [4:0]              rs1_index,
  input  wire [4:0]              rs2_index,
  output logic [31:0]            rs1_value,
  output logic [31:0]            rs2_value,
  output logic                   wb_valid,
  output logic [4:0]             wb_rd,
  output logic [31:0]            wb_value,
  output logic                   retire_valid,
  output core_pkg::retire_t      retire
);

  import core_pkg::*;

  logic [31:0] regs [1:31];  // x0 not stored
  logic [31:0] lane;         // rdata moved down to the addressed byte
  logic [31:0] load_value;

  // --------------------
  // load merge
  // --------------------
  assign lane = rdata >> {executed.addr_low, 3'b000};

  always_comb begin
    case (executed.mem_type)
      mem_byte:   load_value = {{24{lane[7]}}, lane[7:0]};
      mem_byte_u: load_value = {24'b0, lane[7:0]};
      mem_half:   load_value = {{16{lane[15]}}, lane[15:0]};
      mem_half_u: load_value = {16'b0, lane[15:0]};
      default:    load_value = rdata;  // word
    endcase
  end

  // write bus, also seen by execute and decode
  assign wb_valid = exe_valid && executed.writes_reg && executed.rd != 5'd0;
  assign wb_rd    = executed.rd;
  assign wb_value = executed.load ? load_value : executed.result;

  // --------------------
  // register file
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (wb_valid) begin
      regs[wb_rd] <= wb_value;
    end
  end

  // read with bypass of this cycle's write
  always_comb begin
    if (rs1_index == 5'd0)
      rs1_value = '0;
    else if (wb_valid && wb_rd == rs1_index)
      rs1_value = wb_value;
    else
      rs1_value = regs[rs1_index];
    if (rs2_index == 5'd0)
      rs2_value = '0;
    else if (wb_valid && wb_rd == rs2_index)
      rs2_value = wb_value;
    else
      rs2_value = regs[rs2_index];
  end

  // --------------------
  // retire
  // --------------------
  always_ff @(posedge clk) begin
    if (reset)
      retire_valid <= 1'b0;
    else
      retire_valid <= exe_valid;
  end

  always_ff @(posedge clk) begin
    retire.rd      <= executed.rd;
    retire.value   <= wb_valid ? wb_value : 32'd0;  // x0, stores, illegal give zero
    retire.illegal <= executed.illegal;
  end

endmodule

`default_nettype wire

//--- verilog/ramio.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module ramio (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    mem_valid,
  input  core_pkg::mem_req_t     mem_req,
  output logic [31:0]            rdata,
  output logic [5:0]             led
);

  import core_pkg::*;

  localparam int index_bits = $clog2(`RAM_DEPTH_WORDS);
  localparam logic [31:0] led_address = `LED_ADDRESS;

  logic [31:0]           ram [`RAM_DEPTH_WORDS];
  logic [index_bits-1:0] word_index;
  logic                  led_hit;
  logic [3:0]            byte_en;
  logic [31:0]           wdata_lanes;

  // --------------------
  // address decode
  // --------------------
  assign word_index = mem_req.addr[2 +: index_bits];  // wraps modulo depth
  assign led_hit    = mem_req.addr[31:2] == led_address[31:2];

  // byte enables from size and low address bits
  always_comb begin
    case (mem_req.mem_type)
      mem_byte, mem_byte_u: byte_en = 4'b0001 << mem_req.addr[1:0];
      mem_half, mem_half_u: byte_en = 4'b0011 << {mem_req.addr[1], 1'b0};
      mem_word:             byte_en = 4'b1111;
      default:              byte_en = 4'b0000;
    endcase
  end

  // replicate store data over every lane
  always_comb begin
    case (mem_req.mem_type)
      mem_byte, mem_byte_u: wdata_lanes = {4{mem_req.wdata[7:0]}};
      mem_half, mem_half_u: wdata_lanes = {2{mem_req.wdata[15:0]}};
      default:              wdata_lanes = mem_req.wdata;
    endcase
  end

  // --------------------
  // data ram
  // --------------------
  always_ff @(posedge clk) begin
    if (mem_valid && mem_req.write && !led_hit) begin
      for (int i = 0; i < 4; i++)
        if (byte_en[i])
          ram[word_index][8*i +: 8] <= wdata_lanes[8*i +: 8];
    end
    if (mem_valid && !mem_req.write)  // registered read, one cycle
      rdata <= led_hit ? {26'b0, led} : ram[word_index];
  end

  // --------------------
  // led register
  // --------------------
  always_ff @(posedge clk) begin
    if (reset)
      led <= '0;
    else if (mem_valid && mem_req.write && led_hit)
      led <= mem_req.wdata[5:0];  // low six bits, any store size
  end

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top (
  input  wire                    clk,
  input  wire                    reset,
  input  wire [31:0]             instr,
  input  wire                    instr_valid,
  output logic                   retire_valid,
  output core_pkg::retire_t      retire,
  output logic [5:0]             led
);

  import core_pkg::*;

  // register file read port
  logic [4:0]  rs1_index;
  logic [4:0]  rs2_index;
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;

  // stage links
  logic        dec_valid;
  decoded_t    decoded;
  logic        exe_valid;
  executed_t   executed;
  logic        mem_valid;
  mem_req_t    mem_req;
  logic [31:0] rdata;

  // result write bus
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_value;

  // --------------------
  // pipeline
  // --------------------
  instr_decode decode (
    .clk, .reset,
    .instr, .instr_valid,
    .rs1_index, .rs2_index, .rs1_value, .rs2_value,
    .dec_valid, .decoded
  );

  alu_execute execute (
    .clk, .reset,
    .dec_valid, .decoded,
    .wb_valid, .wb_rd, .wb_value,  // forwarding
    .mem_valid, .mem_req,
    .exe_valid, .executed
  );

  result_writeback result (
    .clk, .reset,
    .exe_valid, .executed, .rdata,
    .rs1_index, .rs2_index, .rs1_value, .rs2_value,
    .wb_valid, .wb_rd, .wb_value,
    .retire_valid, .retire
  );

  // --------------------
  // memory and i/o
  // --------------------
  ramio ramio (
    .clk, .reset,
    .mem_valid, .mem_req,
    .rdata,   // next cycle
    .led
  );

endmodule

`default_nettype wire

//--- sim/tb_core_ref.svh
`ifndef TB_CORE_REF_SVH
`define TB_CORE_REF_SVH

// --------------------
// random source
// --------------------

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int count);
  logic [31:0] value;
  logic        fb;
  value = '0;
  for (int i = 0; i < count; i++) begin
    fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr  = {lfsr[30:0], fb};
    value = {value[30:0], fb};
  end
  return value;
endfunction

// --------------------
// encoders
// --------------------
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};  // op-imm and loads
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};  // lui
endfunction

// random legal alu instruction, register or immediate form
function automatic logic [31:0] random_alu();
  logic [31:0] r;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [6:0]  f7;
  r   = rand_bits(32);
  f3  = r[2:0];
  imm = r[14:3];
  f7  = (r[15] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;  // sub, sra
  if (r[16])
    return enc_r(f7, r[21:17], r[26:22], f3, r[31:27]);
  if (f3 == 3'd1 || f3 == 3'd5)
    imm[11:5] = (f3 == 3'd5) ? f7 : 7'h00;  // shift funct7 sits in the immediate
  return enc_i(imm, r[26:22], f3, r[31:27], 7'b0010011);
endfunction

// --------------------
// reference model
// --------------------
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

// runs one instruction on the model state, returns the expected retire record
function automatic retire_t model_step(input logic [31:0] ins);
  retire_t     res;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  logic [31:0] word;
  logic [31:0] value;
  logic [7:0]  bsel;
  logic [15:0] hsel;
  logic        illegal;
  logic        writes;
  logic        led_hit;
  int          idx;
  f3      = ins[14:12];
  f7      = ins[31:25];
  a       = model_regs[ins[19:15]];
  b       = model_regs[ins[24:20]];
  value   = '0;
  illegal = 1'b0;
  writes  = 1'b0;
  case (ins[6:0])
    7'b0110111: begin  // lui
      value  = {ins[31:12], 12'b0};
      writes = 1'b1;
    end
    7'b0110011: begin
      illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      value   = alu_ref(f3, f7[5], a, b);
      writes  = 1'b1;
    end
    7'b0010011: begin
      illegal = (f3 == 3'd1 && f7 != 7'h00) ||
                (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      value   = alu_ref(f3, f3 == 3'd5 && f7[5], a, {{20{ins[31]}}, ins[31:20]});
      writes  = 1'b1;
    end
    7'b0000011: begin  // loads
      addr    = a + {{20{ins[31]}}, ins[31:20]};
      led_hit = addr[31:2] == led_address[31:2];
      idx     = int'(addr[31:2] % `RAM_DEPTH_WORDS);
      word    = led_hit ? {26'b0, model_led} : model_mem[idx];
      bsel    = word[8 * addr[1:0] +: 8];
      hsel    = word[16 * addr[1] +: 16];
      writes  = 1'b1;
      case (f3)
        3'd0:    value = {{24{bsel[7]}}, bsel};
        3'd1:    value = {{16{hsel[15]}}, hsel};
        3'd2:    value = word;
        3'd4:    value = {24'b0, bsel};
        3'd5:    value = {16'b0, hsel};
        default: illegal = 1'b1;
      endcase
    end
    7'b0100011: begin  // stores
      addr    = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
      led_hit = addr[31:2] == led_address[31:2];
      idx     = int'(addr[31:2] % `RAM_DEPTH_WORDS);
      illegal = f3 > 3'd2;
      if (!illegal && led_hit)
        model_led = b[5:0];
      else if (!illegal && f3 == 3'd0)
        model_mem[idx][8 * addr[1:0] +: 8] = b[7:0];
      else if (!illegal && f3 == 3'd1)
        model_mem[idx][16 * addr[1] +: 16] = b[15:0];
      else if (!illegal)
        model_mem[idx] = b;
    end
    default: illegal = 1'b1;
  endcase
  if (illegal)
    writes = 1'b0;
  if (writes && ins[11:7] != 5'd0)
    model_regs[ins[11:7]] = value;
  else
    value = '0;  // x0, stores and illegal retire zero
  res.rd      = ins[11:7];
  res.value   = value;
  res.illegal = illegal;
  return res;
endfunction

`endif

//--- sim/tb_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module tb_core;

  import core_pkg::*;

  localparam logic [31:0] led_address = `LED_ADDRESS;

  logic        clk;
  logic        reset;
  logic [31:0] instr;
  logic        instr_valid;
  logic        retire_valid;
  retire_t     retire;
  logic [5:0]  led;

  // model state
  logic [31:0] lfsr;
  logic [31:0] model_regs [32];
  logic [31:0] model_mem [`RAM_DEPTH_WORDS];  // filled before any load
  logic [5:0]  model_led;

  // in-flight records, oldest first
  retire_t     expected_q [$];
  string       name_q [$];
  int          issue_q [$];
  string       test_name;
  int          cycle;
  int          check_count;
  int          fail_count;
  int          test_fails;
  retire_t     exp_rec;
  string       exp_name;
  int          issued;

  `include "tb_core_ref.svh"

  core_top i_dut (
    .clk, .reset,
    .instr, .instr_valid,
    .retire_valid, .retire,
    .led
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // --------------------
  // stimulus helpers
  // --------------------
  task automatic issue(input logic [31:0] ins);
    expected_q.push_back(model_step(ins));
    name_q.push_back(test_name);
    instr       = ins;
    instr_valid = 1'b1;
    @(posedge clk);
    #10;
    instr_valid = 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #10;
    end
  endtask

  // lui then addi, upper part rounded for the sign of the low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    issue(enc_u(upper[31:12], rd));
    issue(enc_i(value[11:0], rd, 3'd0, rd, 7'b0010011));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      #10;
      waited++;
    end
    if (expected_q.size() != 0) begin
      check_count++;
      fail_count++;
      $display("timeout: %0d instructions never retired in test %s",
               expected_q.size(), test_name);
      expected_q.delete();  // next test starts with nothing in flight
      name_q.delete();
      issue_q.delete();
    end
  endtask

  task automatic end_test();
    drain();
    $display("test %s done, %0d failed checks", test_name, fail_count - test_fails);
    test_fails = fail_count;
  endtask

  task automatic check_led(input logic [5:0] expected);
    check_count++;
    if (led !== expected) begin
      fail_count++;
      $display("Fail %s: expected led %h, actual %h", test_name, expected, led);
    end
  endtask

  // --------------------
  // compare
  // --------------------
  always @(negedge clk) begin
    if (!reset) begin
      cycle++;
      if (instr_valid)
        issue_q.push_back(cycle);  // strobe cycle of each instruction
      if (retire_valid && expected_q.size() == 0) begin
        check_count++;
        fail_count++;
        $display("retire_valid rose with no instruction in flight");
      end else if (retire_valid) begin
        exp_rec  = expected_q.pop_front();
        exp_name = name_q.pop_front();
        issued   = issue_q.pop_front();
        check_count += 2;
        if (retire !== exp_rec) begin
          fail_count++;
          $display("Fail %s: expected rd %0d value %h illegal %b, actual rd %0d value %h illegal %b",
                   exp_name, exp_rec.rd, exp_rec.value, exp_rec.illegal,
                   retire.rd, retire.value, retire.illegal);
        end
        if (cycle - issued != 3) begin
          fail_count++;
          $display("Fail %s latency: expected 3 cycles, actual %0d", exp_name, cycle - issued);
        end
      end
    end
  end

  // --------------------
  // tests
  // --------------------
  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] addr;
    logic [11:0] off;
    logic [1:0]  size;
    logic [4:0]  rd;
    logic [4:0]  rd_dep;
    reset       = 1'b1;
    instr       = '0;
    instr_valid = 1'b0;
    lfsr        = 32'h4d43;
    model_led   = '0;
    cycle       = 0;
    check_count = 0;
    fail_count  = 0;
    test_fails  = 0;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;

    test_name = "reset_lui";
    idle(5);  // nothing may retire here
    check_led(6'd0);
    for (int i = 0; i < 8; i++) begin
      r = rand_bits(20);
      issue(enc_u(r[19:0], 5'(i + 1)));
    end
    issue(enc_u(20'hABCDE, 5'd0));  // x0 retires zero
    end_test();

    test_name = "alu_random";
    for (int i = 0; i < 200; i++)
      issue(random_alu());  // back to back
    end_test();

    test_name = "latency";
    for (int i = 0; i < 24; i++) begin
      issue(random_alu());
      r = rand_bits(2);
      idle(int'(r[1:0]));  // gaps of 0 to 3
    end
    end_test();

    test_name = "memory";
    issue(enc_i(12'h100, 5'd0, 3'd0, 5'd1, 7'b0010011));  // x1 base
    for (int w = 0; w < 16; w++) begin
      addr = 32'h100 + 32'(4 * w);
      load_const(5'd2, (addr * 32'h9e37_79b1) ^ ~addr);
      issue(enc_s(12'(4 * w), 5'd2, 5'd1, 3'd2));
    end
    for (int i = 0; i < 80; i++) begin
      r      = rand_bits(32);
      size   = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
      off    = {6'b0, r[7:2]};
      off    = off & ~((12'd1 << size) - 12'd1);  // aligned to the size
      rd     = (r[13:9] == 5'd1) ? 5'd2 : r[13:9];
      rd_dep = (r[19:15] == 5'd1) ? 5'd3 : r[19:15];
      if (r[8]) begin
        issue(enc_s(off, r[13:9], 5'd1, {1'b0, size}));
      end else begin
        issue(enc_i(off, 5'd1, {r[14] && size != 2'd2, size}, rd, 7'b0000011));
        issue(enc_r(7'h00, rd, rd, 3'd0, rd_dep));  // uses the load at once
      end
    end
    end_test();

    test_name = "led";
    load_const(5'd5, led_address);
    for (int i = 0; i < 4; i++) begin
      r = rand_bits(32);
      load_const(5'd6, r);
      issue(enc_s(12'd0, 5'd6, 5'd5, 3'd2));
      issue(enc_i(12'd0, 5'd5, 3'd2, 5'd7, 7'b0000011));  // read back
      drain();
      check_led(model_led);
    end
    end_test();

    test_name = "illegal";
    issue(enc_i(12'd123, 5'd0, 3'd0, 5'd9, 7'b0010011));
    issue({20'h12345, 5'd9, 7'b1101111});  // jal, not supported
    issue(enc_i(12'd0, 5'd9, 3'd0, 5'd10, 7'b0010011));  // x9 must still hold 123
    end_test();

    $display("checks %0d, passed %0d, failed %0d",
             check_count, check_count - fail_count, fail_count);
    if (fail_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
+incdir+sim
verilog/core_pkg.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/result_writeback.sv
verilog/ramio.sv
verilog/core_top.sv
sim/tb_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_core -f list.f -o tb_core_sim
./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
